// File: src.f
rtl/ahbPkg.sv
rtl/arbiterController.sv
rtl/ahbArbiter.sv
rtl/ahbMemory.sv
rtl/busSubsystem.sv
verification/busSubsystemTb.sv

// File: Makefile
# Verilator build and run for the shared AHB-Lite bus testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --assert --timing -Wno-fatal -j 0
TOP       := busSubsystemTb
FILELIST  := src.f
OBJDIR    := obj_dir
LOG       := sim.log
PASS_MSG  := Test completed successfully

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the simulation and check $(LOG)"
	@echo "  clean  remove the build directory and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	./$(OBJDIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation did not pass, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJDIR) $(LOG)

// File: verification/busSubsystemTb.sv
// Testbench for the shared bus: clock and reset, master tasks,
// reference memory model and assertion checks
`default_nettype none
`timescale 1ns/1ps

module busSubsystemTb;
    import ahbPkg::*;

    localparam int MemWords   = 256;
    // Long data phases so the pending-grant mask matters
    localparam int WaitStates = 3;
    localparam int AddrBits   = $clog2(MemWords);
    // Negedges from raising a lone request to seeing its ready
    localparam int Latency    = WaitStates + 1;
    localparam int MaxWait    = 16 * (WaitStates + 2);

    logic        clk = 1'b0;
    logic        reset;
    logic        requestT;
    logic        requestM;
    logic        requestF;
    ahbAddrPhase addrT;
    ahbAddrPhase addrM;
    ahbAddrPhase addrF;
    logic [31:0] wdataM;
    logic        readyT;
    logic        readyM;
    logic        readyF;
    logic [31:0] rdata;

    // Expected memory contents
    logic [31:0] refMem [MemWords];
    int          seed;
    int          errorCount;
    int          testCount;
    int          failedTests;
    int          testStartErrors;
    int          cycle = 0;
    // Indexed by master select code
    int          doneCycle [3];
    int          episodeCount [3] = '{0, 0, 0};
    int          readyCount [3] = '{0, 0, 0};
    logic [31:0] addrA;
    logic [31:0] addrB;
    logic [31:0] dataA;
    logic [31:0] dataB;

    busSubsystem #(
        .MemWords   (MemWords),
        .WaitStates (WaitStates)
    ) busSubsystem_inst (
        .clk      (clk),
        .reset    (reset),
        .requestT (requestT),
        .requestM (requestM),
        .requestF (requestF),
        .addrT    (addrT),
        .addrM    (addrM),
        .addrF    (addrF),
        .wdataM   (wdataM),
        .readyT   (readyT),
        .readyM   (readyM),
        .readyF   (readyF),
        .rdata    (rdata)
    );

    initial begin
        forever begin
            #2 clk = ~clk;
        end
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    // Every ready pulse, duplicates included
    always @(negedge clk) begin
        if (!reset) begin
            if (readyT) readyCount[masterT]++;
            if (readyM) readyCount[masterM]++;
            if (readyF) readyCount[masterF]++;
        end
    end

    function automatic void reportMismatch(input string msg);
        errorCount++;
        $display("MISMATCH at %0t ns: %s", $time, msg);
    endfunction

    function automatic string masterName(input logic [1:0] who);
        case (who)
            masterT: return "T";
            masterM: return "M";
            default: return "F";
        endcase
    endfunction

    function automatic logic readyOf(input logic [1:0] who);
        case (who)
            masterT: return readyT;
            masterM: return readyM;
            default: return readyF;
        endcase
    endfunction

    // Little-endian lanes picked by size and low address bits
    function automatic logic [31:0] mergeLanes(input logic [31:0] old, input logic [31:0] data,
                                               input logic [1:0] offset, input logic [2:0] size);
        logic [31:0] result;
        result = old;
        for (int lane = 0; lane < 4; lane++) begin
            if (size == sizeWord || (size == sizeHalf && lane[1] == offset[1]) ||
                (size == sizeByte && lane == int'(offset))) begin
                result[lane*8 +: 8] = data[lane*8 +: 8];
            end
        end
        return result;
    endfunction

    function automatic logic [31:0] fillWord(input logic [31:0] addr);
        return (addr * 32'h9E37_79B1) ^ {addr[15:0], addr[31:16]};
    endfunction

    function automatic logic [31:0] randomWordAddr();
        logic [31:0] r;
        r = $random(seed);
        return (r % MemWords) << 2;
    endfunction

    // One request episode of one master, held until its own ready
    task automatic runTransfer(input logic [1:0] who, input logic [31:0] addr,
                               input logic write, input logic [2:0] size,
                               input logic [31:0] data, input logic checkLatency);
        ahbAddrPhase         phase;
        int                  waited;
        logic                seen;
        logic [AddrBits-1:0] idx;
        phase.addr  = addr;
        phase.write = write;
        phase.size  = size;
        idx         = addr[AddrBits+1:2];
        waited      = 0;
        seen        = 1'b0;
        @(negedge clk);
        episodeCount[who]++;
        case (who)
            masterT: begin
                addrT    = phase;
                requestT = 1'b1;
            end
            masterM: begin
                addrM    = phase;
                wdataM   = data;
                requestM = 1'b1;
            end
            default: begin
                addrF    = phase;
                requestF = 1'b1;
            end
        endcase
        while (!seen && waited < MaxWait) begin
            @(negedge clk);
            waited++;
            seen = readyOf(who);
        end
        if (!seen) begin
            errorCount++;
            $display("Timeout: master %s saw no ready within %0d cycles", masterName(who), MaxWait);
        end else begin
            doneCycle[who] = cycle;
            if (checkLatency) begin
                assert (waited == Latency)
                    else reportMismatch($sformatf("master %s ready after %0d cycles, expected %0d",
                                                  masterName(who), waited, Latency));
            end
            if (write) begin
                refMem[idx] = mergeLanes(refMem[idx], data, addr[1:0], size);
            end else begin
                assert (rdata === refMem[idx])
                    else reportMismatch($sformatf("master %s read %h at %h, expected %h",
                                                  masterName(who), rdata, addr, refMem[idx]));
            end
        end
        // Request drops in the ready cycle, address and write data stay put
        case (who)
            masterT: requestT = 1'b0;
            masterM: requestM = 1'b0;
            default: requestF = 1'b0;
        endcase
    endtask

    function automatic void checkSpacing(input logic [1:0] first, input logic [1:0] second);
        assert (doneCycle[second] - doneCycle[first] == Latency)
            else reportMismatch($sformatf("ready of %s came %0d cycles after %s, expected %0d",
                                          masterName(second), doneCycle[second] - doneCycle[first],
                                          masterName(first), Latency));
    endfunction

    task automatic reportTest(input string name);
        testCount++;
        if (errorCount != testStartErrors) begin
            failedTests++;
            $display("Test %0d %s: FAIL with %0d errors", testCount, name,
                     errorCount - testStartErrors);
        end else begin
            $display("Test %0d %s: PASS", testCount, name);
        end
        testStartErrors = errorCount;
    endtask

    // Readies stay low in reset and in the first cycle after it
    resetQuiet: assert property (@(posedge clk)
        (reset || $past(reset)) |-> !(readyT || readyM || readyF))
        else reportMismatch("ready high during reset or right after it");

    oneReadyAtATime: assert property (@(posedge clk) disable iff (reset)
        $onehot0({readyT, readyM, readyF}))
        else reportMismatch("two readies in the same cycle");

    // A ready closes a request that was still up one edge earlier
    readyOwnedT: assert property (@(posedge clk) disable iff (reset)
        readyT |-> $past(requestT))
        else reportMismatch("ready to T with no open request");

    readyOwnedM: assert property (@(posedge clk) disable iff (reset)
        readyM |-> $past(requestM))
        else reportMismatch("ready to M with no open request");

    readyOwnedF: assert property (@(posedge clk) disable iff (reset)
        readyF |-> $past(requestF))
        else reportMismatch("ready to F with no open request");

    initial begin
        seed            = 32'h1362_3e07;
        errorCount      = 0;
        testCount       = 0;
        failedTests     = 0;
        testStartErrors = 0;
        reset           = 1'b1;
        requestT        = 1'b0;
        requestM        = 1'b0;
        requestF        = 1'b0;
        addrT           = '0;
        addrM           = '0;
        addrF           = '0;
        wdataM          = '0;
        repeat (5) @(negedge clk);
        reset = 1'b0;
        repeat (2) @(negedge clk);
        reportTest("reset");

        // Preload so every read has a known answer
        for (int w = 0; w < MemWords; w++) begin
            runTransfer(masterM, 32'(w) << 2, 1'b1, sizeWord, fillWord(32'(w) << 2), 1'b1);
        end
        addrA = randomWordAddr();
        dataA = $random(seed);
        runTransfer(masterM, addrA, 1'b1, sizeWord, dataA, 1'b1);
        runTransfer(masterT, addrA, 1'b0, sizeWord, '0, 1'b1);
        runTransfer(masterF, addrA, 1'b0, sizeWord, '0, 1'b1);
        reportTest("lone transfers");

        // Same word, so T sees old data and F sees M's write
        addrA = randomWordAddr();
        dataA = $random(seed);
        fork
            runTransfer(masterT, addrA, 1'b0, sizeWord, '0, 1'b0);
            runTransfer(masterM, addrA, 1'b1, sizeWord, dataA, 1'b0);
            runTransfer(masterF, addrA, 1'b0, sizeWord, '0, 1'b0);
        join
        checkSpacing(masterT, masterM);
        checkSpacing(masterM, masterF);
        reportTest("three requesters");

        addrA = randomWordAddr();
        addrB = randomWordAddr();
        dataA = $random(seed);
        fork
            runTransfer(masterT, addrA, 1'b0, sizeWord, '0, 1'b0);
            runTransfer(masterM, addrB, 1'b1, sizeWord, dataA, 1'b0);
        join
        checkSpacing(masterT, masterM);
        // TF pair needs the fixed entry condition
        fork
            runTransfer(masterT, addrB, 1'b0, sizeWord, '0, 1'b0);
            runTransfer(masterF, addrA, 1'b0, sizeWord, '0, 1'b0);
        join
        checkSpacing(masterT, masterF);
        dataB = $random(seed);
        fork
            runTransfer(masterM, addrA, 1'b1, sizeWord, dataB, 1'b0);
            runTransfer(masterF, addrA, 1'b0, sizeWord, '0, 1'b0);
        join
        checkSpacing(masterM, masterF);
        reportTest("pair sequences");

        for (int i = 0; i < 4; i++) begin
            addrA = randomWordAddr();
            dataA = $random(seed);
            dataB = $random(seed);
            runTransfer(masterM, {addrA[31:2], dataA[1:0]}, 1'b1, sizeByte, dataB, 1'b1);
            dataB = $random(seed);
            runTransfer(masterM, {addrA[31:2], dataA[1], 1'b0}, 1'b1, sizeHalf, dataB, 1'b1);
            runTransfer(masterT, addrA, 1'b0, sizeWord, '0, 1'b1);
        end
        reportTest("byte and halfword writes");

        // T and F arrive while M's long data phase is still open
        addrA = randomWordAddr();
        addrB = randomWordAddr();
        dataA = $random(seed);
        fork
            runTransfer(masterM, addrA, 1'b1, sizeWord, dataA, 1'b0);
            begin
                @(negedge clk);
                runTransfer(masterT, addrA, 1'b0, sizeWord, '0, 1'b0);
            end
            begin
                repeat (2) @(negedge clk);
                runTransfer(masterF, addrB, 1'b0, sizeWord, '0, 1'b0);
            end
        join
        for (int i = 0; i < 3; i++) begin
            runTransfer(masterF, randomWordAddr(), 1'b0, sizeWord, '0, 1'b1);
        end
        // Idle long enough for a stray second ready to show up
        repeat (Latency + 2) @(negedge clk);
        for (int i = 0; i < 3; i++) begin
            assert (readyCount[i] == episodeCount[i])
                else reportMismatch($sformatf("master %s got %0d readies for %0d requests",
                                              masterName(2'(i)), readyCount[i], episodeCount[i]));
        end
        reportTest("no duplicate grant");

        $display("Summary: %0d tests, %0d failing, %0d errors", testCount, failedTests, errorCount);
        if (errorCount == 0 && failedTests == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: rtl/busSubsystem.sv
// Shared AHB-Lite bus top: three-master arbiter and one memory slave
`default_nettype none
`timescale 1ns/1ps

module busSubsystem #(
    parameter int MemWords   = 256,
    parameter int WaitStates = 1
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                requestT,
    input  logic                requestM,
    input  logic                requestF,
    input  ahbPkg::ahbAddrPhase addrT,
    input  ahbPkg::ahbAddrPhase addrM,
    input  ahbPkg::ahbAddrPhase addrF,
    input  logic [31:0]         wdataM,
    output logic                readyT,
    output logic                readyM,
    output logic                readyF,
    output logic [31:0]         rdata
);
    import ahbPkg::*;

    // Slave side of the bus
    ahbSlaveReq slaveReq;
    logic       hready;

    ahbArbiter ahbArbiter_inst (
        .clk      (clk),
        .reset    (reset),
        .requestT (requestT),
        .requestM (requestM),
        .requestF (requestF),
        .addrT    (addrT),
        .addrM    (addrM),
        .addrF    (addrF),
        .hready   (hready),
        .slaveReq (slaveReq),
        .readyT   (readyT),
        .readyM   (readyM),
        .readyF   (readyF)
    );

    // Only M writes, so its data feeds HWDATA directly
    ahbMemory #(
        .MemWords   (MemWords),
        .WaitStates (WaitStates)
    ) ahbMemory_inst (
        .clk      (clk),
        .reset    (reset),
        .slaveReq (slaveReq),
        .hwdata   (wdataM),
        .hready   (hready),
        .hrdata   (rdata)
    );

endmodule

`default_nettype wire

// File: rtl/ahbMemory.sv
// Word-wide AHB-Lite memory slave with configurable wait states
// and byte-lane writes
`default_nettype none
`timescale 1ns/1ps

module ahbMemory #(
    parameter int MemWords   = 256,
    parameter int WaitStates = 1
) (
    input  logic               clk,
    input  logic               reset,
    input  ahbPkg::ahbSlaveReq slaveReq,
    input  logic [31:0]        hwdata,
    output logic               hready,
    output logic [31:0]        hrdata
);
    import ahbPkg::*;

    localparam int AddrBits  = $clog2(MemWords);
    // At least one bit even with zero wait states
    localparam int CountBits = (WaitStates > 0) ? $clog2(WaitStates + 1) : 1;

    logic [31:0]          mem [MemWords];
    // Address phase taken on the last accepting edge
    ahbSlaveReq           phase;
    logic                 active;
    logic [CountBits-1:0] waitCount;
    logic                 accept;
    logic                 lastCycle;
    logic [AddrBits-1:0]  wordIdx;
    logic [3:0]           laneMask;

    assign lastCycle = active && (waitCount == '0);
    assign hready    = !active || (waitCount == '0);
    assign accept    = slaveReq.trans && hready;
    assign wordIdx   = phase.addr[AddrBits+1:2];

    // Data phase control
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            active    <= 1'b0;
            waitCount <= '0;
        end else if (hready) begin
            // New transfer may overlap the final data cycle
            active    <= accept;
            waitCount <= accept ? CountBits'(WaitStates) : '0;
        end else begin
            waitCount <= waitCount - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            phase <= slaveReq;
        end
    end

    // Lanes from size and low address bits, little endian
    always_comb begin
        case (phase.size)
            sizeByte: laneMask = 4'b0001 << phase.addr[1:0];
            sizeHalf: laneMask = phase.addr[1] ? 4'b1100 : 4'b0011;
            default:  laneMask = 4'b1111;
        endcase
    end

    // Write lands at the end of the last data cycle
    always_ff @(posedge clk) begin
        if (lastCycle && phase.write) begin
            for (int lane = 0; lane < 4; lane++) begin
                if (laneMask[lane]) begin
                    mem[wordIdx][lane*8 +: 8] <= hwdata[lane*8 +: 8];
                end
            end
        end
    end

    // Read word only valid alongside hready in the last cycle
    assign hrdata = (lastCycle && !phase.write) ? mem[wordIdx] : '0;

    halfAligned: assert property (@(posedge clk) disable iff (reset)
        (accept && slaveReq.size == sizeHalf) |-> !slaveReq.addr[0]);

endmodule

`default_nettype wire

// File: rtl/ahbArbiter.sv
// Three-master AHB-Lite arbiter: address-phase mux and HTRANS generation
// around the arbitration controller
`default_nettype none
`timescale 1ns/1ps

module ahbArbiter (
    input  logic                clk,
    input  logic                reset,
    input  logic                requestT,
    input  logic                requestM,
    input  logic                requestF,
    input  ahbPkg::ahbAddrPhase addrT,
    input  ahbPkg::ahbAddrPhase addrM,
    input  ahbPkg::ahbAddrPhase addrF,
    input  logic                hready,
    output ahbPkg::ahbSlaveReq  slaveReq,
    output logic                readyT,
    output logic                readyM,
    output logic                readyF
);
    import ahbPkg::*;

    logic        selT;
    logic        selM;
    logic        selF;
    logic        busRequest;
    logic        busWrite;
    logic [1:0]  addrSel;
    logic [2:0]  busSize;
    // Address phase of the granted master
    ahbAddrPhase picked;

    arbiterController arbiterController_inst (
        .clk        (clk),
        .reset      (reset),
        .requestT   (requestT),
        .requestM   (requestM),
        .requestF   (requestF),
        .writeM     (addrM.write),
        .sizeM      (addrM.size),
        .hready     (hready),
        .readyT     (readyT),
        .readyM     (readyM),
        .readyF     (readyF),
        .selT       (selT),
        .selM       (selM),
        .selF       (selF),
        .busRequest (busRequest),
        .busWrite   (busWrite),
        .addrSel    (addrSel),
        .busSize    (busSize)
    );

    always_comb begin
        case (addrSel)
            masterM: picked = addrM;
            masterF: picked = addrF;
            default: picked = addrT;
        endcase
    end

    // Write and size come from the controller, not the mux
    always_comb begin
        slaveReq.addr  = picked.addr;
        slaveReq.write = busWrite;
        slaveReq.size  = busSize;
        // IDLE when every requester is masked
        slaveReq.trans = busRequest & (selT | selM | selF);
    end

    // Masters hold address and control, grant is frozen in wait states
    reqStable: assert property (@(posedge clk) disable iff (reset)
        (slaveReq.trans && !hready) |=> $stable(slaveReq));

    // Read-only masters never present a write
    readOnlyTF: assert property (@(posedge clk) disable iff (reset)
        (slaveReq.trans && addrSel != masterM) |-> !picked.write);

endmodule

`default_nettype wire

// File: rtl/arbiterController.sv
// Fixed-priority arbitration FSM for three AHB masters (T, M, F)
// with grant selects, data-phase owner tracking and per-master readies
`default_nettype none
`timescale 1ns/1ps

module arbiterController (
    input  logic       clk,
    input  logic       reset,
    input  logic       requestT,
    input  logic       requestM,
    input  logic       requestF,
    input  logic       writeM,
    input  logic [2:0] sizeM,
    input  logic       hready,
    output logic       readyT,
    output logic       readyM,
    output logic       readyF,
    output logic       selT,
    output logic       selM,
    output logic       selF,
    output logic       busRequest,
    output logic       busWrite,
    output logic [1:0] addrSel,
    output logic [2:0] busSize
);
    import ahbPkg::*;

    // One state per simultaneous-request sequence
    typedef enum logic [2:0] {SINGLE, TMF2, TMF3, MF, TM, TF} arbState;

    arbState    state;
    arbState    nextState;

    // Bit order {T, M, F} throughout
    logic [2:0] sel;
    logic [2:0] ready;
    // Owner of the data phase in flight
    logic [2:0] prevSel;
    // Grant shown during a wait state, kept until hready
    logic [2:0] waitSel;
    logic       holdGrant;
    logic       noDataPending;
    // Requests not blocked by their own pending data phase
    logic       freeT;
    logic       freeM;
    logic       freeF;

    assign busRequest    = requestT | requestM | requestF;
    assign noDataPending = ~|prevSel;
    assign holdGrant     = |waitSel;

    assign freeT = requestT & ~prevSel[2];
    assign freeM = requestM & ~prevSel[1];
    assign freeF = requestF & ~prevSel[0];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= SINGLE;
        end else begin
            state <= nextState;
        end
    end

    // Sequences start only from the master actually granted
    always_comb begin
        nextState = state;
        case (state)
            SINGLE: begin
                if (hready) begin
                    if (selT && freeM && freeF) begin
                        nextState = TMF2;
                    end else if (selT && freeM) begin
                        nextState = TM;
                    end else if (selT && freeF) begin
                        // TF checks the T/F pair itself
                        nextState = TF;
                    end else if (selM && freeF && !freeT) begin
                        nextState = MF;
                    end
                end
            end
            TMF2: begin
                if (hready) begin
                    nextState = TMF3;
                end
            end
            TMF3, MF, TM, TF: begin
                if (hready) begin
                    nextState = SINGLE;
                end
            end
            default: nextState = SINGLE;
        endcase
    end

    // Grant selects
    always_comb begin
        sel = 3'b000;
        case (state)
            SINGLE: begin
                if (holdGrant) begin
                    sel = waitSel;
                end else if (freeT) begin
                    sel = 3'b100;
                end else if (freeM) begin
                    sel = 3'b010;
                end else if (freeF) begin
                    sel = 3'b001;
                end
            end
            TMF2, TM:     sel = 3'b010;
            TMF3, MF, TF: sel = 3'b001;
            default:      sel = 3'b000;
        endcase
    end

    assign {selT, selM, selF} = sel;

    always_comb begin
        case (sel)
            3'b010:  addrSel = masterM;
            3'b001:  addrSel = masterF;
            default: addrSel = masterT;
        endcase
    end

    // Only M ever writes; T and F fetch full words
    assign busWrite = writeM & selM;
    assign busSize  = selM ? sizeM : sizeWord;

    // Freeze the grant while the slave stretches a data phase
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            waitSel <= 3'b000;
        end else begin
            waitSel <= hready ? 3'b000 : sel;
        end
    end

    // Address phase becomes data phase on the next accepting edge
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            prevSel <= 3'b000;
        end else if (hready || noDataPending) begin
            prevSel <= sel;
        end
    end

    assign ready = prevSel & {3{hready}};
    assign {readyT, readyM, readyF} = ready;

    // Data phase tracked only after the slave really took the address
    for (genvar i = 0; i < 3; i++) begin : pendingChecks
        pendingFromAccept: assert property (@(posedge clk) disable iff (reset)
            $rose(prevSel[i]) |-> $past(sel[i] && hready));
    end

endmodule

`default_nettype wire

// File: rtl/ahbPkg.sv
// AHB-Lite bus structs, transfer size codes and master select codes
// shared by the arbiter, its controller and the memory slave
`default_nettype none

package ahbPkg;

    // HSIZE encodings used on this bus
    localparam logic [2:0] sizeByte = 3'd0;
    localparam logic [2:0] sizeHalf = 3'd1;
    localparam logic [2:0] sizeWord = 3'd2;

    // Address mux select per master
    // T = translation walker, M = data memory stage, F = fetch stage
    localparam logic [1:0] masterT = 2'd0;
    localparam logic [1:0] masterM = 2'd1;
    localparam logic [1:0] masterF = 2'd2;

    // One master's address phase, 36 bits
    typedef struct packed {
        logic [31:0] addr;
        logic        write;
        logic [2:0]  size;
    } ahbAddrPhase;

    // Slave-side address phase, 37 bits
    typedef struct packed {
        logic [31:0] addr;
        logic        write;
        logic [2:0]  size;
        // High for NONSEQ, low for IDLE
        logic        trans;
    } ahbSlaveReq;

endpackage

`default_nettype wire
